// File: backend_pkg.sv
package backend_pkg;

    localparam int XLEN       = 32;  // Data path width
    localparam int REG_ADDR_W = 5;   // Register file address width
    localparam int CNT_W      = 64;  // Stable counter width

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,  // Shift amount from low 5 bits
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7   // Signed compare, result 0 or 1
    } alu_op_t;

    // Lane B result select, one-hot
    typedef enum logic [3:0] {
        SEL_ALU    = 4'b0001,
        SEL_LOAD   = 4'b0010,
        SEL_CNT_LO = 4'b0100,
        SEL_CNT_HI = 4'b1000
    } wb_sel_t;

    typedef struct packed {
        logic                  valid;
        alu_op_t               op;
        logic [REG_ADDR_W-1:0] src1_addr;
        logic [REG_ADDR_W-1:0] src2_addr;
        logic [XLEN-1:0]       src1_data;  // Register file read, not yet forwarded
        logic [XLEN-1:0]       src2_data;
        logic [XLEN-1:0]       imm;
        logic                  use_imm;    // Immediate replaces src2
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] waddr;
        wb_sel_t               wb_sel;     // Lane B only
        logic                  mem_we;     // Lane B store
    } lane_issue_t;

    typedef struct packed {
        logic            rvalid;
        logic            wvalid;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    // Stage result or register file write port
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } rf_write_t;

endpackage

// File: pipe_control.sv
`timescale 1ns/1ns

module pipe_control (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] ex_valid,   // {lane B, lane A}
    input  logic       ex_mem_op,
    input  logic       mem_ready,
    output logic       stall,
    output logic [1:0] mem_valid,
    output logic [1:0] wb_valid
);

    logic mem_op_pend;  // Memory stage holds a load or store

    // Waiting on the data memory
    assign stall = mem_op_pend & ~mem_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid   <= 2'b00;
            wb_valid    <= 2'b00;
            mem_op_pend <= 1'b0;
        end else if (stall) begin
            wb_valid <= 2'b00;  // Bubble into writeback, memory stage holds
        end else begin
            mem_valid   <= ex_valid;
            mem_op_pend <= ex_mem_op;
            wb_valid    <= mem_valid;
        end
    end

endmodule

// File: operand_forward.sv
`timescale 1ns/1ns

module operand_forward
    import backend_pkg::*;
(
    input  lane_issue_t     issue_a,
    input  lane_issue_t     issue_b,
    input  rf_write_t       mem_a,
    input  rf_write_t       mem_b,
    input  rf_write_t       wb_a,
    input  rf_write_t       wb_b,
    output logic [XLEN-1:0] opnd_a1,
    output logic [XLEN-1:0] opnd_a2,
    output logic [XLEN-1:0] opnd_b1,
    output logic [XLEN-1:0] opnd_b2
);

    // Youngest matching writer wins
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_ADDR_W-1:0] raddr,
        input logic [XLEN-1:0]       rf_data,
        input rf_write_t             m_b,
        input rf_write_t             m_a,
        input rf_write_t             w_b,
        input rf_write_t             w_a
    );
        logic [XLEN-1:0] value;
        value = rf_data;
        if (raddr != '0) begin  // r0 reads as the file value
            if (m_b.we && m_b.waddr == raddr) begin
                value = m_b.wdata;
            end else if (m_a.we && m_a.waddr == raddr) begin
                value = m_a.wdata;
            end else if (w_b.we && w_b.waddr == raddr) begin
                value = w_b.wdata;
            end else if (w_a.we && w_a.waddr == raddr) begin
                value = w_a.wdata;
            end
        end
        return value;
    endfunction

    assign opnd_a1 = pick_operand(issue_a.src1_addr, issue_a.src1_data, mem_b, mem_a, wb_b, wb_a);
    assign opnd_a2 = pick_operand(issue_a.src2_addr, issue_a.src2_data, mem_b, mem_a, wb_b, wb_a);
    assign opnd_b1 = pick_operand(issue_b.src1_addr, issue_b.src1_data, mem_b, mem_a, wb_b, wb_a);
    assign opnd_b2 = pick_operand(issue_b.src2_addr, issue_b.src2_data, mem_b, mem_a, wb_b, wb_a);

endmodule

// File: lane_alu.sv
`timescale 1ns/1ns

module lane_alu
    import backend_pkg::*;
(
    input  alu_op_t         op,
    input  logic [XLEN-1:0] opnd1,
    input  logic [XLEN-1:0] opnd2,
    input  logic [XLEN-1:0] imm,
    input  logic            use_imm,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] src2;
    logic [4:0]      shamt;

    assign src2  = use_imm ? imm : opnd2;
    assign shamt = src2[4:0];  // Shift amount

    always_comb begin
        case (op)
            ALU_ADD: result = opnd1 + src2;
            ALU_SUB: result = opnd1 - src2;
            ALU_AND: result = opnd1 & src2;
            ALU_OR:  result = opnd1 | src2;
            ALU_XOR: result = opnd1 ^ src2;
            ALU_SLL: result = opnd1 << shamt;
            ALU_SRL: result = opnd1 >> shamt;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(opnd1) < $signed(src2)};
            default: result = '0;
        endcase
    end

endmodule

// File: stage_regs.sv
`timescale 1ns/1ns

module stage_regs
    import backend_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  lane_issue_t     issue_a,
    input  lane_issue_t     issue_b,
    input  logic [XLEN-1:0] alu_a,
    input  logic [XLEN-1:0] alu_b,
    input  logic [XLEN-1:0] store_data,
    input  logic            stall,
    input  logic [1:0]      mem_valid,   // {lane B, lane A}
    input  logic [1:0]      wb_valid,
    input  logic [XLEN-1:0] mem_rdata,
    output mem_req_t        mem_req,
    output rf_write_t       mem_a,       // Forwardable memory stage results
    output rf_write_t       mem_b,
    output rf_write_t       wb_a,
    output rf_write_t       wb_b
);

    logic [CNT_W-1:0] cnt;         // Free-running stable counter
    rf_write_t        mem_a_q;
    rf_write_t        mem_b_q;
    wb_sel_t          mem_sel_b;
    logic [CNT_W-1:0] mem_cnt;     // Counter value of the execute cycle
    logic [XLEN-1:0]  mem_result_b;
    rf_write_t        wb_a_q;
    rf_write_t        wb_b_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;  // Keeps counting through stalls
        end
    end

    // Data memory request, only when lane B advances
    assign mem_req = '{
        rvalid: issue_b.valid & (issue_b.wb_sel == SEL_LOAD) & ~stall,
        wvalid: issue_b.valid & issue_b.mem_we & ~stall,
        addr:   alu_b,
        wdata:  store_data
    };

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_a_q   <= '{we: issue_a.rf_we, waddr: issue_a.waddr, wdata: alu_a};
            mem_b_q   <= '{we: issue_b.rf_we, waddr: issue_b.waddr, wdata: alu_b};
            mem_sel_b <= issue_b.wb_sel;
            mem_cnt   <= cnt;
        end
    end

    // Loads and counter reads are not ready for bypass yet
    assign mem_a = '{
        we:    mem_a_q.we & mem_valid[0],
        waddr: mem_a_q.waddr,
        wdata: mem_a_q.wdata
    };
    assign mem_b = '{
        we:    mem_b_q.we & mem_valid[1] & (mem_sel_b == SEL_ALU),
        waddr: mem_b_q.waddr,
        wdata: mem_b_q.wdata
    };

    assign mem_result_b = ({XLEN{mem_sel_b[0]}} & mem_b_q.wdata)
                        | ({XLEN{mem_sel_b[1]}} & mem_rdata)
                        | ({XLEN{mem_sel_b[2]}} & mem_cnt[XLEN-1:0])
                        | ({XLEN{mem_sel_b[3]}} & mem_cnt[CNT_W-1:XLEN]);

    // Bubbles are marked by wb_valid
    always_ff @(posedge clk) begin
        wb_a_q <= mem_a_q;
        wb_b_q <= '{we: mem_b_q.we, waddr: mem_b_q.waddr, wdata: mem_result_b};
    end

    assign wb_a = '{we: wb_a_q.we & wb_valid[0], waddr: wb_a_q.waddr, wdata: wb_a_q.wdata};
    assign wb_b = '{we: wb_b_q.we & wb_valid[1], waddr: wb_b_q.waddr, wdata: wb_b_q.wdata};

endmodule

// File: issue_backend.sv
`timescale 1ns/1ns

module issue_backend
    import backend_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  lane_issue_t     issue_a,    // Older lane
    input  lane_issue_t     issue_b,    // Younger lane, memory and counter
    input  logic            mem_ready,
    input  logic [XLEN-1:0] mem_rdata,
    output mem_req_t        mem_req,
    output logic            stall,
    output rf_write_t       wb_a,
    output rf_write_t       wb_b
);

    logic            ex_mem_op;
    logic [1:0]      mem_valid;
    logic [1:0]      wb_valid;
    logic [XLEN-1:0] opnd_a1;
    logic [XLEN-1:0] opnd_a2;
    logic [XLEN-1:0] opnd_b1;
    logic [XLEN-1:0] opnd_b2;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    rf_write_t       mem_fwd_a;
    rf_write_t       mem_fwd_b;

    // Lane B load or store in execute
    assign ex_mem_op = issue_b.valid & (issue_b.mem_we | (issue_b.wb_sel == SEL_LOAD));

    pipe_control u_pipe_control (
        .clk       (clk),
        .reset     (reset),
        .ex_valid  ({issue_b.valid, issue_a.valid}),
        .ex_mem_op (ex_mem_op),
        .mem_ready (mem_ready),
        .stall     (stall),
        .mem_valid (mem_valid),
        .wb_valid  (wb_valid)
    );

    operand_forward u_operand_forward (
        .issue_a (issue_a),
        .issue_b (issue_b),
        .mem_a   (mem_fwd_a),
        .mem_b   (mem_fwd_b),
        .wb_a    (wb_a),
        .wb_b    (wb_b),
        .opnd_a1 (opnd_a1),
        .opnd_a2 (opnd_a2),
        .opnd_b1 (opnd_b1),
        .opnd_b2 (opnd_b2)
    );

    lane_alu u_alu_a (
        .op      (issue_a.op),
        .opnd1   (opnd_a1),
        .opnd2   (opnd_a2),
        .imm     (issue_a.imm),
        .use_imm (issue_a.use_imm),
        .result  (alu_a)
    );

    lane_alu u_alu_b (
        .op      (issue_b.op),
        .opnd1   (opnd_b1),
        .opnd2   (opnd_b2),
        .imm     (issue_b.imm),
        .use_imm (issue_b.use_imm),
        .result  (alu_b)            // Also the memory address
    );

    stage_regs u_stage_regs (
        .clk        (clk),
        .reset      (reset),
        .issue_a    (issue_a),
        .issue_b    (issue_b),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .store_data (opnd_b2),      // Forwarded src2 of the store
        .stall      (stall),
        .mem_valid  (mem_valid),
        .wb_valid   (wb_valid),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .mem_a      (mem_fwd_a),
        .mem_b      (mem_fwd_b),
        .wb_a       (wb_a),
        .wb_b       (wb_b)
    );

endmodule

// File: tb_issue_backend.sv
`timescale 1ns/1ns

module tb_issue_backend;
    import backend_pkg::*;

    localparam logic [31:0] SEED = 32'h64fbca97;
    localparam int N_INIT = 8;
    localparam int N_ALU  = 40;
    localparam int N_DEP  = 40;
    localparam int N_MEM  = 16;
    localparam int N_CNT  = 8;
    localparam int TOTAL_INSTR = 2 * (N_INIT + N_ALU + N_DEP + 2 + 3 * N_MEM + 2 * N_CNT + 8);
    localparam int TIMEOUT = TOTAL_INSTR * 6 + 100;

    typedef struct packed {
        logic                  lane;   // 0 for wb_a, 1 for wb_b
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } exp_wb_t;

    logic            clk = 1'b0;
    logic            reset = 1'b1;
    lane_issue_t     issue_a;
    lane_issue_t     issue_b;
    logic            mem_ready = 1'b0;
    logic [XLEN-1:0] mem_rdata = '0;
    mem_req_t        mem_req;
    logic            stall;
    rf_write_t       wb_a;
    rf_write_t       wb_b;

    logic [XLEN-1:0]  shadow [32];      // Registers after every issued pair
    logic [XLEN-1:0]  lag1 [32];        // Registers one pair behind
    logic [XLEN-1:0]  lag2 [32];        // Register file as read in execute
    logic [XLEN-1:0]  shadow_mem [64];
    logic [XLEN-1:0]  mem_model [64];
    exp_wb_t          exp_q [$];
    logic [63:0]      store_q [$];      // {addr, wdata} of issued stores
    logic [CNT_W-1:0] cyc;              // Cycles since reset release
    int               wd_cnt = 0;
    string            cur_test = "reset";
    logic             stall_q = 1'b0;   // Stall of the previous cycle
    logic             pend = 1'b0;
    logic             p_we;
    logic [5:0]       p_idx = '0;
    logic [XLEN-1:0]  p_wdata;
    int               wait_cnt;

    issue_backend u_dut (
        .clk       (clk),
        .reset     (reset),
        .issue_a   (issue_a),
        .issue_b   (issue_b),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .stall     (stall),
        .wb_a      (wb_a),
        .wb_b      (wb_b)
    );

    always #2 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        stop_on_error("Value mismatch");
    endtask

    function automatic logic [XLEN-1:0] alu_ref(input alu_op_t op, input logic [XLEN-1:0] x,
                                                input logic [XLEN-1:0] y);
        case (op)
            ALU_ADD: return x + y;
            ALU_SUB: return x - y;
            ALU_AND: return x & y;
            ALU_OR:  return x | y;
            ALU_XOR: return x ^ y;
            ALU_SLL: return x << y[4:0];
            ALU_SRL: return x >> y[4:0];
            default: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic lane_issue_t make_lane(input alu_op_t op, input int s1, input int s2,
                                              input logic [XLEN-1:0] imm, input logic use_imm,
                                              input logic we, input int waddr);
        lane_issue_t l;
        l = '0;
        l.valid = 1'b1;
        l.op = op;
        l.src1_addr = s1;
        l.src2_addr = s2;
        l.imm = imm;
        l.use_imm = use_imm;
        l.rf_we = we;
        l.waddr = waddr;
        l.wb_sel = SEL_ALU;
        return l;
    endfunction

    function automatic lane_issue_t idle_lane();
        lane_issue_t l;
        l = '0;
        l.wb_sel = SEL_ALU;
        return l;
    endfunction

    function automatic int rand_reg();
        return 1 + $urandom % 15;
    endfunction

    // Lane B must not read what lane A of the same pair writes
    function automatic int avoid(input int r, input lane_issue_t a);
        return (a.valid && a.rf_we && a.waddr == r) ? 0 : r;
    endfunction

    task automatic issue_pair(input lane_issue_t a_in, input lane_issue_t b_in);
        lane_issue_t     a;
        lane_issue_t     b;
        logic [XLEN-1:0] a_res;
        logic [XLEN-1:0] b_alu;
        logic [XLEN-1:0] b_res;
        a = a_in;
        b = b_in;
        a.src1_data = lag2[a.src1_addr];
        a.src2_data = lag2[a.src2_addr];
        b.src1_data = lag2[b.src1_addr];
        b.src2_data = lag2[b.src2_addr];
        if (b.valid && b.mem_we) begin
            store_q.push_back({shadow[b.src1_addr] + b.imm, shadow[b.src2_addr]});
        end
        issue_a <= a;
        issue_b <= b;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
        a_res = alu_ref(a.op, shadow[a.src1_addr], a.use_imm ? a.imm : shadow[a.src2_addr]);
        b_alu = alu_ref(b.op, shadow[b.src1_addr], b.use_imm ? b.imm : shadow[b.src2_addr]);
        case (b.wb_sel)
            SEL_LOAD:   b_res = shadow_mem[b_alu[7:2]];
            SEL_CNT_LO: b_res = cyc[31:0];  // Execute cycle count
            SEL_CNT_HI: b_res = cyc[63:32];
            default:    b_res = b_alu;
        endcase
        if (a.valid && a.rf_we) exp_q.push_back('{1'b0, a.waddr, a_res});
        if (b.valid && b.rf_we) exp_q.push_back('{1'b1, b.waddr, b_res});
        if (b.valid && b.mem_we) shadow_mem[b_alu[7:2]] = shadow[b.src2_addr];
        lag2 = lag1;
        lag1 = shadow;
        if (a.valid && a.rf_we && a.waddr != 0) shadow[a.waddr] = a_res;
        if (b.valid && b.rf_we && b.waddr != 0) shadow[b.waddr] = b_res;
    endtask

    task automatic check_wb(input logic lane, input rf_write_t w);
        exp_wb_t exp;
        if (exp_q.size() == 0) begin
            stop_on_error("Writeback seen with no instruction expected");
        end else begin
            exp = exp_q.pop_front();
            assert (exp == {lane, w.waddr, w.wdata})
                else report_mismatch(cur_test, 64'(exp), 64'({lane, w.waddr, w.wdata}));
        end
    endtask

    always @(posedge clk) begin
        if (reset) cyc <= '0;
        else cyc <= cyc + 1'b1;
    end

    always @(posedge clk) begin
        wd_cnt <= wd_cnt + 1;
        if (wd_cnt >= TIMEOUT) stop_on_error("Timeout, the run did not finish in time");
    end

    always @(posedge clk) begin
        if (!reset) begin
            // Writeback takes a bubble after every stalled cycle
            assert (!(stall_q && (wb_a.we || wb_b.we)))
                else stop_on_error("Write enable high right after a stalled cycle");
            if (wb_a.we) check_wb(1'b0, wb_a);
            if (wb_b.we) check_wb(1'b1, wb_b);
        end
        stall_q <= stall;
    end

    // Data memory with 0 to 3 cycles of ready delay
    always @(posedge clk) begin
        if (pend && mem_ready) begin
            if (p_we) mem_model[p_idx] = p_wdata;
            pend = 1'b0;
        end else if (pend) begin
            wait_cnt = wait_cnt - 1;
        end
        if (!reset && mem_req.wvalid) begin
            if (store_q.size() == 0) begin
                stop_on_error("Store request with no store issued");
            end else begin
                assert (store_q[0] == {mem_req.addr, mem_req.wdata})
                    else report_mismatch(cur_test, store_q[0], {mem_req.addr, mem_req.wdata});
                void'(store_q.pop_front());
            end
        end
        if (!reset && (mem_req.rvalid || mem_req.wvalid)) begin
            pend = 1'b1;
            p_we = mem_req.wvalid;
            p_idx = mem_req.addr[7:2];
            p_wdata = mem_req.wdata;
            wait_cnt = $urandom % 4;
        end
        mem_ready <= pend && wait_cnt == 0;
        mem_rdata <= mem_model[p_idx];
    end

    initial begin
        lane_issue_t a;
        lane_issue_t b;
        int          d;
        int          prev_d;
        int          w;
        void'($urandom(SEED));
        issue_a = idle_lane();
        issue_b = idle_lane();
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
            lag1[i] = '0;
            lag2[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            shadow_mem[i] = 32'hc0de0000 ^ (i * 32'h01000193);
            mem_model[i] = 32'hc0de0000 ^ (i * 32'h01000193);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        assert ({stall, wb_a.we, wb_b.we, mem_req.rvalid, mem_req.wvalid} == 5'b0)
            else report_mismatch(cur_test, 64'd0,
                                 {stall, wb_a.we, wb_b.we, mem_req.rvalid, mem_req.wvalid});

        cur_test = "alu_random";
        for (int k = 0; k < N_INIT; k++) begin  // Load known values into r1 to r16
            issue_pair(make_lane(ALU_ADD, 0, 0, $urandom, 1'b1, 1'b1, 2 * k + 1),
                       make_lane(ALU_ADD, 0, 0, $urandom, 1'b1, 1'b1, 2 * k + 2));
        end
        for (int k = 0; k < N_ALU; k++) begin
            a = make_lane(alu_op_t'($urandom % 8), rand_reg(), rand_reg(), $urandom,
                          $urandom % 2, $urandom % 4 != 0, rand_reg());
            a.valid = $urandom % 8 != 0;
            b = make_lane(alu_op_t'($urandom % 8), avoid(rand_reg(), a), avoid(rand_reg(), a),
                          $urandom, $urandom % 2, $urandom % 4 != 0, rand_reg());
            b.valid = $urandom % 8 != 0;
            issue_pair(a, b);
        end

        cur_test = "forward_dep";
        prev_d = rand_reg();
        for (int k = 0; k < N_DEP; k++) begin
            do d = ($urandom % 6 == 0) ? 0 : rand_reg(); while (d == prev_d);
            a = make_lane(alu_op_t'($urandom % 8), prev_d, ($urandom % 4 == 0) ? 0 : rand_reg(),
                          $urandom, $urandom % 2, 1'b1, d);
            w = rand_reg();
            b = make_lane(alu_op_t'($urandom % 8), (w == d) ? 0 : w, prev_d,
                          $urandom, 1'b0, 1'b1, d);  // Both lanes share a destination
            issue_pair(a, b);
            prev_d = d;
        end

        cur_test = "store_load";
        issue_pair(make_lane(ALU_ADD, 0, 0, 32'h100, 1'b1, 1'b1, 20), idle_lane());
        issue_pair(idle_lane(), idle_lane());  // Base in r20 written back before the loads
        for (int k = 0; k < N_MEM; k++) begin
            w = $urandom % 8;
            a = make_lane(alu_op_t'($urandom % 8), rand_reg(), rand_reg(), $urandom,
                          $urandom % 2, 1'b1, rand_reg());
            b = make_lane(ALU_ADD, 20, avoid(rand_reg(), a), w * 4, 1'b1, 1'b0, 0);
            b.mem_we = 1'b1;
            issue_pair(a, b);
            b = make_lane(ALU_ADD, 20, 0, w * 4, 1'b1, 1'b1, rand_reg());
            b.wb_sel = SEL_LOAD;
            issue_pair(idle_lane(), b);
            issue_pair(idle_lane(), idle_lane());  // No use of the load result next cycle
        end

        cur_test = "counter_read";
        for (int k = 0; k < N_CNT; k++) begin
            b = make_lane(ALU_ADD, 0, 0, 0, 1'b1, 1'b1, rand_reg());
            b.wb_sel = (k % 2 == 0) ? SEL_CNT_LO : SEL_CNT_HI;
            issue_pair(make_lane(ALU_XOR, rand_reg(), 0, $urandom, 1'b1, 1'b1, 21), b);
            issue_pair(idle_lane(), idle_lane());
        end

        cur_test = "drain";
        repeat (4) issue_pair(idle_lane(), idle_lane());
        if (exp_q.size() == 0 && store_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_on_error("Expected writebacks or stores never appeared");
        end
    end

endmodule

// File: issue_backend.f
backend_pkg.sv
pipe_control.sv
operand_forward.sv
lane_alu.sv
stage_regs.sv
issue_backend.sv
tb_issue_backend.sv
